//--- build.f
+incdir+dv
source/codec_pkg.sv
source/ctrl_decode.sv
source/alu_field_decode.sv
source/addr_gen.sv
source/codec_decode.sv
dv/codec_decode_tb.sv

//--- Bender.yml
package:
  name: codec_decode

sources:
  - source/codec_pkg.sv
  - source/ctrl_decode.sv
  - source/alu_field_decode.sv
  - source/addr_gen.sv
  - source/codec_decode.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/codec_decode_tb.sv

//--- dv/codec_model.svh
`ifndef CODEC_MODEL_SVH
`define CODEC_MODEL_SVH

// Expected decoder state per strobe
logic [17:0]        m_flags;
logic               m_a_only;
logic [SHIFT_W-1:0] m_shift [3];  // p2, p3, p4
logic [2:0]         m_plus;       // p2, p3, p4
logic [ADDR_W-1:0]  m_base;
logic [ADDR_W-1:0]  m_phys_a;
logic [ADDR_W-1:0]  m_phys_b;

// Flag order is p2 {t_left ram_left a_right wr_a} then p3 {t_left a_right wr_a}
// then p4 {t y ram inport} left, {a y} right and {wr_t wr_a wr_y memory outport}
function automatic logic [17:0] table_flags(input logic [OP_W-1:0] op);
  case (op)
    4'h1:    return {4'b0101, 3'b000, 11'b0010_10_11000};
    4'h2:    return {4'b1011, 3'b111, 11'b1000_10_01000};
    4'h3:    return {4'b1011, 3'b111, 11'b0100_10_00100};
    4'h4:    return {4'b0000, 3'b111, 11'b0100_10_00100};
    4'h5:    return {4'b0000, 3'b000, 11'b0100_10_00100};
    4'h6:    return {4'b0000, 3'b000, 11'b0000_00_00100};
    4'h7:    return {4'b0000, 3'b000, 11'b0000_01_00010};
    4'h8:    return {4'b0000, 3'b000, 11'b0001_00_00010};
    4'h9:    return {4'b0000, 3'b000, 11'b0010_00_00001};
    4'ha:    return {4'b0000, 3'b000, 11'b0010_00_00100};
    4'hb:    return {4'b1011, 3'b011, 11'b0100_10_00100};
    4'hc:    return {4'b0101, 3'b000, 11'b0010_00_10000};
    4'hd:    return {4'b0000, 3'b000, 11'b0000_10_00010};
    default: return '0;  // 0, E and F
  endcase
endfunction

task automatic model_reset();
  m_flags  = '0;
  m_a_only = 1'b1;
  m_shift  = '{default: '0};
  m_plus   = '0;
  m_base   = '0;
  m_phys_a = '0;
  m_phys_b = '0;
endtask

task automatic model_step(input micro_word_u w);
  logic dual;
  dual       = (w.addr.op == 4'h1) || (w.addr.op == 4'hc);
  m_flags    = table_flags(w.addr.op);
  m_a_only   = !dual;
  m_shift[0] = dual ? '0 : w.alu.shift_p2;  // Address bits here
  m_shift[1] = w.alu.shift_p3;
  m_shift[2] = w.alu.shift_p4;
  m_plus     = dual ? 3'b000 : {w.alu.plus_p2, w.alu.plus_p3, w.alu.plus_p4};
  m_phys_a   = m_base + w.addr.addr_a;     // Old base and wrap at 32
  m_phys_b   = m_base + w.addr.addr_b;
  if (w.addr.op == 4'hf)
    m_base = m_base - 1'b1;
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  checks++;
  if (!timed_out && act !== exp) begin
    $display("CHECK FAILED %s: expected %0b, actual %0b", name, exp, act);
    errors++;
  end
endtask

task automatic check_shift(input string name, input logic [SHIFT_W-1:0] exp,
                           input logic [SHIFT_W-1:0] act);
  checks++;
  if (!timed_out && act !== exp) begin
    $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
    errors++;
  end
endtask

task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                          input logic [ADDR_W-1:0] act);
  checks++;
  if (!timed_out && act !== exp) begin
    $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
    errors++;
  end
endtask

`endif

//--- dv/codec_decode_tb.sv
`timescale 1ns/1ps

module codec_decode_tb import codec_pkg::*; ();

  localparam int CLK_PERIOD = 20;

  logic               sys_clk = 1'b0;
  logic               resetb;
  logic               p4;
  micro_word_u        rom_data;
  logic               addr_a_cycle;
  logic               p2_t_left, p2_ram_left, p2_a_right, p2_write_reg_a;
  logic               p3_t_left, p3_a_right, p3_write_reg_a;
  logic               p4_t_left, p4_y_left, p4_ram_left, p4_inport_left;
  logic               p4_a_right, p4_y_right;
  logic               p4_write_reg_t, p4_write_reg_a, p4_write_reg_y;
  logic               p4_write_memory, p4_write_outport, addr_a_only;
  logic [SHIFT_W-1:0] p2_shift, p3_shift, p4_shift;
  logic               p2_plus, p3_plus, p4_plus;
  logic [ADDR_W-1:0]  ram_addr;
  logic [17:0]        dut_flags;

  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          failed_tests = 0;
  int          test_start;
  logic        timed_out = 1'b0;
  logic [31:0] seed = 32'd30;
  logic [OP_W-1:0] cycle_ops [4] = '{4'h1, 4'hc, 4'h2, 4'h9};

  `include "codec_model.svh"

  assign dut_flags = {p2_t_left, p2_ram_left, p2_a_right, p2_write_reg_a,
                      p3_t_left, p3_a_right, p3_write_reg_a,
                      p4_t_left, p4_y_left, p4_ram_left, p4_inport_left,
                      p4_a_right, p4_y_right, p4_write_reg_t, p4_write_reg_a,
                      p4_write_reg_y, p4_write_memory, p4_write_outport};

  codec_decode codec_decode_inst (.*);

  always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic micro_word_u random_word(input logic [OP_W-1:0] op);
    logic [31:0] r;
    r = lcg_next();
    return {op, r[31:10]};  // Upper LCG bits are the better ones
  endfunction

  // Every edge has its own timeout
  task wait_clock(input int n, input logic falling);
    int seen;
    seen = 0;
    while (seen < n && !timed_out) begin
      fork
        if (falling)
          @(negedge sys_clk);
        else
          @(posedge sys_clk);
        #(4 * CLK_PERIOD) timed_out = 1'b1;
      join_any
      disable fork;
      if (timed_out)
        $display("Timeout: no clock edge seen within %0d ns", 4 * CLK_PERIOD);
      seen++;
    end
  endtask

  task automatic strobe(input micro_word_u w);
    wait_clock(1, 1'b0);
    p4       <= 1'b1;
    rom_data <= w;
    wait_clock(1, 1'b0);  // DUT latches here
    p4 <= 1'b0;
    model_step(w);
    wait_clock(1, 1'b1);
  endtask

  task automatic drive_cycle(input logic value);
    wait_clock(1, 1'b0);
    addr_a_cycle <= value;
    wait_clock(1, 1'b1);
  endtask

  task automatic idle_cycle();
    logic [31:0] r;
    r = lcg_next();
    wait_clock(1, 1'b0);
    rom_data <= r[31:6];  // Bus noise while the strobe stays low
    wait_clock(1, 1'b1);
  endtask

  task automatic check_outputs(input string name);
    logic [ADDR_W-1:0] exp_addr;
    exp_addr = (m_a_only || addr_a_cycle) ? m_phys_a : m_phys_b;
    for (int i = 17; i >= 0; i--)
      check_flag($sformatf("%s flag %0d", name, 17 - i), m_flags[i], dut_flags[i]);
    check_flag({name, " addr_a_only"}, m_a_only, addr_a_only);
    check_shift({name, " p2_shift"}, m_shift[0], p2_shift);
    check_shift({name, " p3_shift"}, m_shift[1], p3_shift);
    check_shift({name, " p4_shift"}, m_shift[2], p4_shift);
    check_flag({name, " p2_plus"}, m_plus[2], p2_plus);
    check_flag({name, " p3_plus"}, m_plus[1], p3_plus);
    check_flag({name, " p4_plus"}, m_plus[0], p4_plus);
    check_addr({name, " ram_addr"}, exp_addr, ram_addr);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_start) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: FAIL, %0d errors", name, errors - test_start);
    end
  endtask

  initial begin
    logic [31:0] r;
    micro_word_u w;
    resetb       = 1'b0;
    p4           = 1'b0;
    rom_data     = '0;
    addr_a_cycle = 1'b0;
    model_reset();
    wait_clock(2, 1'b0);
    resetb <= 1'b1;
    wait_clock(1, 1'b1);

    test_start = errors;
    check_outputs("reset");
    end_test("reset");

    test_start = errors;
    for (int op = 0; op < 16; op++) begin
      strobe(random_word(OP_W'(op)));
      check_outputs($sformatf("opcode_table op %0h", op));
    end
    end_test("opcode_table");

    test_start = errors;
    for (int k = 0; k < 24; k++) begin
      r = lcg_next();
      strobe(random_word(r[31:28]));
      check_outputs("alu_fields");
    end
    end_test("alu_fields");

    test_start = errors;
    for (int k = 0; k < 40; k++) begin
      r = lcg_next();
      strobe(random_word((r[31:30] == 2'b00) ? 4'hf : r[27:24]));  // Plenty of F
      check_outputs("base_walk");
    end
    end_test("base_walk");

    test_start = errors;
    foreach (cycle_ops[k]) begin
      w = random_word(cycle_ops[k]);
      w.addr.addr_b = ~w.addr.addr_a;  // Physical A and B always differ
      strobe(w);
      drive_cycle(1'b1);
      check_outputs("addr_cycle high");
      drive_cycle(1'b0);
      check_outputs("addr_cycle low");
    end
    end_test("addr_cycle");

    test_start = errors;
    strobe(random_word(4'h3));
    for (int k = 0; k < 8; k++) begin
      idle_cycle();
      check_outputs("idle_hold");
    end
    end_test("idle_hold");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed_tests, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- source/codec_decode.sv
`timescale 1ns/1ps

module codec_decode import codec_pkg::*; (
  input  logic               sys_clk,
  input  logic               resetb,
  input  logic               p4,
  input  micro_word_u        rom_data,
  input  logic               addr_a_cycle,
  output logic               p2_t_left,
  output logic               p2_ram_left,
  output logic               p2_a_right,
  output logic               p2_write_reg_a,
  output logic               p3_t_left,
  output logic               p3_a_right,
  output logic               p3_write_reg_a,
  output logic               p4_t_left,
  output logic               p4_y_left,
  output logic               p4_ram_left,
  output logic               p4_inport_left,
  output logic               p4_a_right,
  output logic               p4_y_right,
  output logic               p4_write_reg_t,
  output logic               p4_write_reg_a,
  output logic               p4_write_reg_y,
  output logic               p4_write_memory,
  output logic               p4_write_outport,
  output logic               addr_a_only,
  output logic [SHIFT_W-1:0] p2_shift,
  output logic [SHIFT_W-1:0] p3_shift,
  output logic [SHIFT_W-1:0] p4_shift,
  output logic               p2_plus,
  output logic               p3_plus,
  output logic               p4_plus,
  output logic [ADDR_W-1:0]  ram_addr
);

  logic dual_fetch;
  logic base_step;

  ctrl_decode ctrl_decode_inst (
    .sys_clk          (sys_clk),
    .resetb           (resetb),
    .p4               (p4),
    .rom_data         (rom_data),
    .p2_t_left        (p2_t_left),
    .p2_ram_left      (p2_ram_left),
    .p2_a_right       (p2_a_right),
    .p2_write_reg_a   (p2_write_reg_a),
    .p3_t_left        (p3_t_left),
    .p3_a_right       (p3_a_right),
    .p3_write_reg_a   (p3_write_reg_a),
    .p4_t_left        (p4_t_left),
    .p4_y_left        (p4_y_left),
    .p4_ram_left      (p4_ram_left),
    .p4_inport_left   (p4_inport_left),
    .p4_a_right       (p4_a_right),
    .p4_y_right       (p4_y_right),
    .p4_write_reg_t   (p4_write_reg_t),
    .p4_write_reg_a   (p4_write_reg_a),
    .p4_write_reg_y   (p4_write_reg_y),
    .p4_write_memory  (p4_write_memory),
    .p4_write_outport (p4_write_outport),
    .addr_a_only      (addr_a_only),
    .dual_fetch       (dual_fetch),
    .base_step        (base_step)
  );

  alu_field_decode alu_field_decode_inst (
    .sys_clk    (sys_clk),
    .resetb     (resetb),
    .p4         (p4),
    .rom_data   (rom_data),
    .dual_fetch (dual_fetch),
    .p2_shift   (p2_shift),
    .p3_shift   (p3_shift),
    .p4_shift   (p4_shift),
    .p2_plus    (p2_plus),
    .p3_plus    (p3_plus),
    .p4_plus    (p4_plus)
  );

  addr_gen addr_gen_inst (
    .sys_clk      (sys_clk),
    .resetb       (resetb),
    .p4           (p4),
    .rom_data     (rom_data),
    .base_step    (base_step),
    .addr_a_only  (addr_a_only),  // Registered flag, same edge as the addresses
    .addr_a_cycle (addr_a_cycle),
    .ram_addr     (ram_addr)
  );

endmodule

//--- source/addr_gen.sv
`timescale 1ns/1ps

module addr_gen import codec_pkg::*; (
  input  logic              sys_clk,
  input  logic              resetb,
  input  logic              p4,
  input  micro_word_u       rom_data,
  input  logic              base_step,
  input  logic              addr_a_only,
  input  logic              addr_a_cycle,
  output logic [ADDR_W-1:0] ram_addr
);

  logic [ADDR_W-1:0] base_addr;
  logic [ADDR_W-1:0] phys_addr_a;
  logic [ADDR_W-1:0] phys_addr_b;

  // Circular buffer base, moves down one slot per base-step word
  always_ff @(posedge sys_clk) begin
    if (!resetb) begin
      base_addr <= '0;
    end else if (p4 && base_step) begin
      base_addr <= base_addr - 1'b1;
    end
  end

  // Sums use the base from before this strobe and wrap at 32
  always_ff @(posedge sys_clk) begin
    if (!resetb) begin
      phys_addr_a <= '0;
      phys_addr_b <= '0;
    end else if (p4) begin
      phys_addr_a <= base_addr + rom_data.addr.addr_a;
      phys_addr_b <= base_addr + rom_data.addr.addr_b;
    end
  end

  // Second address only on the B half of a dual fetch
  assign ram_addr = (addr_a_only || addr_a_cycle) ? phys_addr_a : phys_addr_b;

endmodule

//--- source/alu_field_decode.sv
`timescale 1ns/1ps

module alu_field_decode import codec_pkg::*; (
  input  logic               sys_clk,
  input  logic               resetb,
  input  logic               p4,
  input  micro_word_u        rom_data,
  input  logic               dual_fetch,
  output logic [SHIFT_W-1:0] p2_shift,
  output logic [SHIFT_W-1:0] p3_shift,
  output logic [SHIFT_W-1:0] p4_shift,
  output logic               p2_plus,
  output logic               p3_plus,
  output logic               p4_plus
);

  always_ff @(posedge sys_clk) begin
    if (!resetb) begin
      p2_shift <= '0;
      p3_shift <= '0;
      p4_shift <= '0;
      p2_plus  <= 1'b0;
      p3_plus  <= 1'b0;
      p4_plus  <= 1'b0;
    end else if (p4) begin
      p3_shift <= rom_data.alu.shift_p3;
      p4_shift <= rom_data.alu.shift_p4;
      // Address bits overlap these fields on dual-fetch words
      if (dual_fetch) begin
        p2_shift <= '0;
        p2_plus  <= 1'b0;
        p3_plus  <= 1'b0;
        p4_plus  <= 1'b0;
      end else begin
        p2_shift <= rom_data.alu.shift_p2;
        p2_plus  <= rom_data.alu.plus_p2;
        p3_plus  <= rom_data.alu.plus_p3;
        p4_plus  <= rom_data.alu.plus_p4;
      end
    end
  end

endmodule

//--- source/ctrl_decode.sv
`timescale 1ns/1ps

module ctrl_decode import codec_pkg::*; (
  input  logic        sys_clk,
  input  logic        resetb,
  input  logic        p4,
  input  micro_word_u rom_data,
  output logic        p2_t_left,
  output logic        p2_ram_left,
  output logic        p2_a_right,
  output logic        p2_write_reg_a,
  output logic        p3_t_left,
  output logic        p3_a_right,
  output logic        p3_write_reg_a,
  output logic        p4_t_left,
  output logic        p4_y_left,
  output logic        p4_ram_left,
  output logic        p4_inport_left,
  output logic        p4_a_right,
  output logic        p4_y_right,
  output logic        p4_write_reg_t,
  output logic        p4_write_reg_a,
  output logic        p4_write_reg_y,
  output logic        p4_write_memory,
  output logic        p4_write_outport,
  output logic        addr_a_only,
  output logic        dual_fetch,
  output logic        base_step
);

  logic [OP_W-1:0] op;

  assign op = rom_data.addr.op;

  // Words that carry two RAM addresses instead of arithmetic fields
  assign dual_fetch = (op == OP_ADD_MEM) || (op == OP_LOAD_MEM);
  assign base_step  = (op == OP_BASE_DEC);

  always_ff @(posedge sys_clk) begin
    if (!resetb) begin
      {p2_t_left, p2_ram_left, p2_a_right, p2_write_reg_a,
       p3_t_left, p3_a_right, p3_write_reg_a,
       p4_t_left, p4_y_left, p4_ram_left, p4_inport_left, p4_a_right, p4_y_right,
       p4_write_reg_t, p4_write_reg_a, p4_write_reg_y,
       p4_write_memory, p4_write_outport} <= '0;
      addr_a_only <= 1'b1;
    end else if (p4) begin
      {p2_t_left, p2_ram_left, p2_a_right, p2_write_reg_a,
       p3_t_left, p3_a_right, p3_write_reg_a,
       p4_t_left, p4_y_left, p4_ram_left, p4_inport_left, p4_a_right, p4_y_right,
       p4_write_reg_t, p4_write_reg_a, p4_write_reg_y,
       p4_write_memory, p4_write_outport} <= '0;
      addr_a_only <= ~dual_fetch;
      case (op)
        OP_ADD_MEM: begin
          p2_ram_left    <= 1'b1;
          p2_write_reg_a <= 1'b1;
          p4_ram_left    <= 1'b1;
          p4_a_right     <= 1'b1;
          p4_write_reg_a <= 1'b1;
          p4_write_reg_t <= 1'b1;
        end
        OP_FILTER3: begin
          p2_t_left      <= 1'b1;
          p2_a_right     <= 1'b1;
          p2_write_reg_a <= 1'b1;
          p3_t_left      <= 1'b1;
          p3_a_right     <= 1'b1;
          p3_write_reg_a <= 1'b1;
          p4_t_left      <= 1'b1;
          p4_a_right     <= 1'b1;
          p4_write_reg_a <= 1'b1;
        end
        OP_FILTER_Y: begin
          p2_t_left      <= 1'b1;
          p2_a_right     <= 1'b1;
          p2_write_reg_a <= 1'b1;
          p3_t_left      <= 1'b1;
          p3_a_right     <= 1'b1;
          p3_write_reg_a <= 1'b1;
          p4_y_left      <= 1'b1;
          p4_a_right     <= 1'b1;
          p4_write_reg_y <= 1'b1;
        end
        OP_FILTER_Y2: begin  // Idle in phase two
          p3_t_left      <= 1'b1;
          p3_a_right     <= 1'b1;
          p3_write_reg_a <= 1'b1;
          p4_y_left      <= 1'b1;
          p4_a_right     <= 1'b1;
          p4_write_reg_y <= 1'b1;
        end
        OP_FILTER_Y1: begin
          p4_y_left      <= 1'b1;
          p4_a_right     <= 1'b1;
          p4_write_reg_y <= 1'b1;
        end
        OP_CLEAR_Y:   p4_write_reg_y <= 1'b1;  // Nothing on either operand
        OP_STORE_Y: begin
          p4_y_right      <= 1'b1;
          p4_write_memory <= 1'b1;
        end
        OP_IMPORT: begin
          p4_inport_left  <= 1'b1;
          p4_write_memory <= 1'b1;
        end
        OP_EXPORT: begin
          p4_ram_left      <= 1'b1;
          p4_write_outport <= 1'b1;
        end
        OP_LOAD_Y: begin
          p4_ram_left    <= 1'b1;
          p4_write_reg_y <= 1'b1;
        end
        OP_FILTER_YB: begin
          p2_t_left      <= 1'b1;
          p2_a_right     <= 1'b1;
          p2_write_reg_a <= 1'b1;
          p3_a_right     <= 1'b1;  // Zero left operand in phase three
          p3_write_reg_a <= 1'b1;
          p4_y_left      <= 1'b1;
          p4_a_right     <= 1'b1;
          p4_write_reg_y <= 1'b1;
        end
        OP_LOAD_MEM: begin
          p2_ram_left    <= 1'b1;
          p2_write_reg_a <= 1'b1;
          p4_ram_left    <= 1'b1;
          p4_write_reg_t <= 1'b1;
        end
        OP_STORE_A: begin
          p4_a_right      <= 1'b1;
          p4_write_memory <= 1'b1;
        end
        OP_NOP, OP_BASE_DEC: ;  // Base update lives in addr_gen
        default: ;
      endcase
    end
  end

endmodule

//--- source/codec_pkg.sv
package codec_pkg;

  localparam int WORD_W  = 26;
  localparam int OP_W    = 4;
  localparam int ADDR_W  = 5;
  localparam int SHIFT_W = 4;

  localparam logic [OP_W-1:0] OP_NOP       = 4'h0;
  localparam logic [OP_W-1:0] OP_ADD_MEM   = 4'h1;  // Two RAM reads, A + T
  localparam logic [OP_W-1:0] OP_FILTER3   = 4'h2;
  localparam logic [OP_W-1:0] OP_FILTER_Y  = 4'h3;
  localparam logic [OP_W-1:0] OP_FILTER_Y2 = 4'h4;
  localparam logic [OP_W-1:0] OP_FILTER_Y1 = 4'h5;
  localparam logic [OP_W-1:0] OP_CLEAR_Y   = 4'h6;
  localparam logic [OP_W-1:0] OP_STORE_Y   = 4'h7;
  localparam logic [OP_W-1:0] OP_IMPORT    = 4'h8;
  localparam logic [OP_W-1:0] OP_EXPORT    = 4'h9;
  localparam logic [OP_W-1:0] OP_LOAD_Y    = 4'ha;
  localparam logic [OP_W-1:0] OP_FILTER_YB = 4'hb;
  localparam logic [OP_W-1:0] OP_LOAD_MEM  = 4'hc;  // Two RAM reads into A and T
  localparam logic [OP_W-1:0] OP_STORE_A   = 4'hd;
  localparam logic [OP_W-1:0] OP_BASE_DEC  = 4'hf;

  // Address view, used by the dual-fetch words
  typedef struct packed {
    logic [OP_W-1:0]                    op;
    logic [1:0]                         rsvd_hi;
    logic [ADDR_W-1:0]                  addr_a;
    logic [1:0]                         rsvd_mid;
    logic [ADDR_W-1:0]                  addr_b;
    logic [WORD_W-OP_W-2*ADDR_W-5:0]    rsvd_lo;
  } micro_addr_t;

  // Arithmetic view, signs are 0 for add and 1 for subtract
  typedef struct packed {
    logic [OP_W-1:0]                    op;
    logic [WORD_W-OP_W-3*SHIFT_W-4:0]   rsvd;
    logic                               plus_p2;
    logic                               plus_p3;
    logic                               plus_p4;
    logic [SHIFT_W-1:0]                 shift_p2;
    logic [SHIFT_W-1:0]                 shift_p3;
    logic [SHIFT_W-1:0]                 shift_p4;
  } micro_alu_t;

  typedef union packed {
    micro_addr_t addr;
    micro_alu_t  alu;
  } micro_word_u;

endpackage
